//--- hdl/cache_controller.sv
// memory bus arbiter with data cache priority and response steering
`timescale 1ns/1ps

module cache_controller
	import mem_bus_pkg::*;
(
	// instruction cache side
	input  bus_command_t icache_req_command,
	input  addr_t        icache_req_addr,
	output mem_tag_t     icache_grant_tag,

	// data cache side
	input  bus_command_t dcache_req_command,
	input  addr_t        dcache_req_addr,
	input  block_t       dcache_req_wdata,
	output mem_tag_t     dcache_grant_tag,

	// memory side
	output bus_command_t mem_command,
	output addr_t        mem_addr,
	output block_t       mem_wdata,
	input  mem_tag_t     mem_response
);

	// data cache wins whenever it asks
	logic dcache_owns;
	logic icache_owns;

	assign dcache_owns = dcache_req_command != BUS_NONE;
	assign icache_owns = !dcache_owns && (icache_req_command != BUS_NONE);

	////////////////////
	// request mux
	////////////////////

	always_comb begin
		if (dcache_owns) begin
			mem_command = dcache_req_command;
			mem_addr = dcache_req_addr;
			mem_wdata = dcache_req_wdata;
		end else begin
			// icache only loads
			mem_command = icache_req_command;
			mem_addr = icache_req_addr;
			mem_wdata = '0;
		end
	end

	////////////////////
	// response steering
	////////////////////

	// the cache that lost sees zero and retries next cycle
	always_comb begin
		dcache_grant_tag = '0;
		icache_grant_tag = '0;
		if (dcache_owns)
			dcache_grant_tag = mem_response;
		else if (icache_owns)
			icache_grant_tag = mem_response;
	end

endmodule

//--- hdl/cache_pkg.sv
// access sizes, block geometry and sub-block extract and merge helpers
package cache_pkg;
	import mem_bus_pkg::*;

	////////////////////
	// geometry
	////////////////////

	// byte offset inside a 64-bit block
	parameter int BLOCK_OFFSET_BITS = 3;

	// access size encoding
	typedef enum logic [1:0] {
		BYTE   = 2'h0,
		HALF   = 2'h1,
		WORD   = 2'h2,
		DOUBLE = 2'h3
	} mem_size_t;

	////////////////////
	// helpers
	////////////////////

	// low-aligned mask covering one access of the given size
	function automatic block_t size_mask(mem_size_t size);
		case (size)
			BYTE:    return 64'h0000_0000_0000_00ff;
			HALF:    return 64'h0000_0000_0000_ffff;
			WORD:    return 64'h0000_0000_ffff_ffff;
			default: return 64'hffff_ffff_ffff_ffff;
		endcase
	endfunction

	// addressed sub-block, zero extended
	function automatic block_t extract_value(block_t line,
			logic [BLOCK_OFFSET_BITS-1:0] offset, mem_size_t size);
		block_t shifted;
		shifted = line >> {offset, 3'b000};
		return shifted & size_mask(size);
	endfunction

	// write a sized value into the block at the byte offset
	function automatic block_t merge_value(block_t line,
			logic [BLOCK_OFFSET_BITS-1:0] offset, mem_size_t size, block_t value);
		block_t mask;
		mask = size_mask(size) << {offset, 3'b000};
		return (line & ~mask) | ((value << {offset, 3'b000}) & mask);
	endfunction

endpackage

//--- hdl/dcache.sv
// direct-mapped write-through, write-allocate data cache for sized accesses
`timescale 1ns/1ps

module dcache
	import mem_bus_pkg::*;
	import cache_pkg::*;
#(
	parameter int DCACHE_LINES = 16
) (
	input  logic         clock,
	input  logic         reset,
	input  bus_command_t dcache_command,
	input  addr_t        dcache_addr,
	input  mem_size_t    dcache_size,
	input  block_t       dcache_wdata,
	output block_t       dcache_rdata,
	output logic         dcache_finished,
	output bus_command_t dcache_req_command,
	output addr_t        dcache_req_addr,
	output block_t       dcache_req_wdata,
	input  mem_tag_t     dcache_grant_tag,
	input  mem_tag_t     mem_tag,
	input  block_t       mem_rdata
);

	localparam int INDEX_BITS = $clog2(DCACHE_LINES);
	localparam int TAG_BITS = XLEN - INDEX_BITS - BLOCK_OFFSET_BITS;

	typedef enum logic [2:0] {
		IDLE,
		LOOKUP,
		FETCH,
		FILL_WAIT,
		WRITE,
		DONE
	} dcache_state_t;

	dcache_state_t state, next_state;

	// line storage
	logic [TAG_BITS-1:0]     tag_array [DCACHE_LINES];
	block_t                  data_array [DCACHE_LINES];
	logic [DCACHE_LINES-1:0] valid_array;

	// registered command
	bus_command_t req_command;
	addr_t        req_addr;
	mem_size_t    req_size;
	block_t       req_wdata;

	logic [INDEX_BITS-1:0]        req_index;
	logic [TAG_BITS-1:0]          req_line_tag;
	logic [BLOCK_OFFSET_BITS-1:0] req_offset;
	logic                         hit;

	// tag of the block fetch in flight
	mem_tag_t fetch_tag;
	logic     granted;
	logic     fill;

	assign req_index = req_addr[BLOCK_OFFSET_BITS +: INDEX_BITS];
	assign req_line_tag = req_addr[XLEN-1 -: TAG_BITS];
	assign req_offset = req_addr[BLOCK_OFFSET_BITS-1:0];
	assign hit = valid_array[req_index] && (tag_array[req_index] == req_line_tag);

	assign granted = dcache_grant_tag != '0;
	assign fill = (state == FILL_WAIT) && (mem_tag == fetch_tag);

	////////////////////
	// state machine
	////////////////////

	always_comb begin
		next_state = state;
		case (state)
			IDLE:      if (dcache_command != BUS_NONE) next_state = LOOKUP;
			LOOKUP: begin
				// a miss allocates for loads and stores alike
				if (!hit)
					next_state = FETCH;
				else if (req_command == BUS_STORE)
					next_state = WRITE;
				else
					next_state = IDLE;
			end
			FETCH:     if (granted) next_state = FILL_WAIT;
			FILL_WAIT: if (fill) next_state = LOOKUP;
			WRITE:     if (granted) next_state = DONE;
			default:   next_state = IDLE;
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= IDLE;
			valid_array <= '0;
		end else begin
			state <= next_state;
			if (fill)
				valid_array[req_index] <= 1'b1;
		end
	end

	////////////////////
	// datapath
	////////////////////

	always_ff @(posedge clock) begin
		if (state == IDLE && dcache_command != BUS_NONE) begin
			req_command <= dcache_command;
			req_addr <= dcache_addr;
			req_size <= dcache_size;
			req_wdata <= dcache_wdata;
		end
		if (state == FETCH && granted)
			fetch_tag <= dcache_grant_tag;
		if (fill) begin
			data_array[req_index] <= mem_rdata;
			tag_array[req_index] <= req_line_tag;
		end else if (state == LOOKUP && hit && req_command == BUS_STORE) begin
			// merged line is what goes out on the write-through
			data_array[req_index] <= merge_value(data_array[req_index], req_offset,
				req_size, req_wdata);
		end
	end

	// load hit finishes in lookup, store finishes after acceptance
	assign dcache_finished = (state == LOOKUP && hit && req_command == BUS_LOAD)
		|| (state == DONE);
	assign dcache_rdata = extract_value(data_array[req_index], req_offset, req_size);

	// bus request, held until granted
	always_comb begin
		case (state)
			FETCH:   dcache_req_command = BUS_LOAD;
			WRITE:   dcache_req_command = BUS_STORE;
			default: dcache_req_command = BUS_NONE;
		endcase
	end
	assign dcache_req_addr = {req_addr[XLEN-1:BLOCK_OFFSET_BITS], {BLOCK_OFFSET_BITS{1'b0}}};
	assign dcache_req_wdata = data_array[req_index];

	// outside holds its command until the finish pulse
	finished_with_command: assert property (@(posedge clock) disable iff (reset)
		dcache_finished |-> dcache_command != BUS_NONE);

	finished_is_pulse: assert property (@(posedge clock) disable iff (reset)
		dcache_finished |=> !dcache_finished);

	// controller steers a response here only while this cache requests
	grant_only_when_requesting: assert property (@(posedge clock) disable iff (reset)
		granted |-> dcache_req_command != BUS_NONE);

endmodule

//--- hdl/icache.sv
// direct-mapped instruction cache with one outstanding miss
`timescale 1ns/1ps

module icache
	import mem_bus_pkg::*;
	import cache_pkg::*;
#(
	parameter int ICACHE_LINES = 32
) (
	input  logic         clock,
	input  logic         reset,
	input  addr_t        fetch_addr,
	output block_t       fetch_data,
	output logic         fetch_valid,
	output bus_command_t icache_req_command,
	output addr_t        icache_req_addr,
	input  mem_tag_t     icache_grant_tag,
	input  mem_tag_t     mem_tag,
	input  block_t       mem_rdata
);

	localparam int INDEX_BITS = $clog2(ICACHE_LINES);
	localparam int TAG_BITS = XLEN - INDEX_BITS - BLOCK_OFFSET_BITS;

	// line storage
	logic [TAG_BITS-1:0]     tag_array [ICACHE_LINES];
	block_t                  data_array [ICACHE_LINES];
	logic [ICACHE_LINES-1:0] valid_array;

	// current fetch address split
	logic [INDEX_BITS-1:0] fetch_index;
	logic [TAG_BITS-1:0]   fetch_tag;
	logic                  hit;

	// outstanding miss
	logic                  miss_pending;
	mem_tag_t              miss_tag;
	logic [INDEX_BITS-1:0] miss_index;
	logic [TAG_BITS-1:0]   miss_line_tag;
	logic                  granted;
	logic                  fill;

	////////////////////
	// lookup
	////////////////////

	assign fetch_index = fetch_addr[BLOCK_OFFSET_BITS +: INDEX_BITS];
	assign fetch_tag = fetch_addr[XLEN-1 -: TAG_BITS];
	assign hit = valid_array[fetch_index] && (tag_array[fetch_index] == fetch_tag);

	// hit is purely combinational from the address
	assign fetch_valid = hit;
	assign fetch_data = data_array[fetch_index];

	////////////////////
	// miss handling
	////////////////////

	// quiet in reset, then one miss at a time, retried every cycle until granted
	assign icache_req_command = (!reset && !hit && !miss_pending) ? BUS_LOAD : BUS_NONE;
	assign icache_req_addr = {fetch_addr[XLEN-1:BLOCK_OFFSET_BITS], {BLOCK_OFFSET_BITS{1'b0}}};

	assign granted = (icache_req_command == BUS_LOAD) && (icache_grant_tag != '0);
	assign fill = miss_pending && (mem_tag == miss_tag);

	always_ff @(posedge clock) begin
		if (reset) begin
			valid_array <= '0;
			miss_pending <= 1'b0;
			miss_tag <= '0;
		end else if (fill) begin
			valid_array[miss_index] <= 1'b1;
			miss_pending <= 1'b0;
		end else if (granted) begin
			miss_pending <= 1'b1;
			miss_tag <= icache_grant_tag;
		end
	end

	// fill goes to the line recorded at grant, even if fetch_addr moved on
	always_ff @(posedge clock) begin
		if (fill) begin
			data_array[miss_index] <= mem_rdata;
			tag_array[miss_index] <= miss_line_tag;
		end
		if (granted) begin
			miss_index <= fetch_index;
			miss_line_tag <= fetch_tag;
		end
	end

	// data for a tag never shows before that tag is held as pending
	no_data_before_pending: assert property (@(posedge clock) disable iff (reset)
		granted |-> mem_tag != icache_grant_tag);

endmodule

//--- hdl/mem_bus_pkg.sv
// tagged memory bus widths, types and command encoding
package mem_bus_pkg;

	////////////////////
	// widths
	////////////////////

	// byte address width
	parameter int XLEN = 32;

	// one memory block, also the bus data width
	parameter int BLOCK_BITS = 64;

	// transaction tag width
	parameter int MEM_TAG_BITS = 4;

	////////////////////
	// types
	////////////////////

	typedef logic [XLEN-1:0] addr_t;

	typedef logic [BLOCK_BITS-1:0] block_t;

	// zero means no response or no data this cycle
	typedef logic [MEM_TAG_BITS-1:0] mem_tag_t;

	// shared by the bus and the data cache command port
	typedef enum logic [1:0] {
		BUS_NONE  = 2'h0,
		BUS_LOAD  = 2'h1,
		BUS_STORE = 2'h2
	} bus_command_t;

endpackage

//--- hdl/mem_subsystem.sv
// memory subsystem top: instruction cache, data cache and bus controller
`timescale 1ns/1ps

module mem_subsystem
	import mem_bus_pkg::*;
	import cache_pkg::*;
#(
	parameter int ICACHE_LINES = 32,
	parameter int DCACHE_LINES = 16
) (
	input  logic         clock,
	input  logic         reset,

	// fetch port
	input  addr_t        fetch_addr,
	output block_t       fetch_data,
	output logic         fetch_valid,

	// data port
	input  bus_command_t dcache_command,
	input  addr_t        dcache_addr,
	input  mem_size_t    dcache_size,
	input  block_t       dcache_wdata,
	output block_t       dcache_rdata,
	output logic         dcache_finished,

	// memory bus
	output bus_command_t mem_command,
	output addr_t        mem_addr,
	output block_t       mem_wdata,
	input  mem_tag_t     mem_response,
	input  block_t       mem_rdata,
	input  mem_tag_t     mem_tag
);

	// cache to controller
	bus_command_t icache_req_command;
	addr_t        icache_req_addr;
	mem_tag_t     icache_grant_tag;
	bus_command_t dcache_req_command;
	addr_t        dcache_req_addr;
	block_t       dcache_req_wdata;
	mem_tag_t     dcache_grant_tag;

	////////////////////
	// caches
	////////////////////

	icache #(
		.ICACHE_LINES(ICACHE_LINES)
	) icache_i (
		.clock(clock),
		.reset(reset),
		.fetch_addr(fetch_addr),
		.fetch_data(fetch_data),
		.fetch_valid(fetch_valid),
		.icache_req_command(icache_req_command),
		.icache_req_addr(icache_req_addr),
		.icache_grant_tag(icache_grant_tag),
		.mem_tag(mem_tag),
		.mem_rdata(mem_rdata)
	);

	// load data and tag go to both caches, each matches its own tag
	dcache #(
		.DCACHE_LINES(DCACHE_LINES)
	) dcache_i (
		.clock(clock),
		.reset(reset),
		.dcache_command(dcache_command),
		.dcache_addr(dcache_addr),
		.dcache_size(dcache_size),
		.dcache_wdata(dcache_wdata),
		.dcache_rdata(dcache_rdata),
		.dcache_finished(dcache_finished),
		.dcache_req_command(dcache_req_command),
		.dcache_req_addr(dcache_req_addr),
		.dcache_req_wdata(dcache_req_wdata),
		.dcache_grant_tag(dcache_grant_tag),
		.mem_tag(mem_tag),
		.mem_rdata(mem_rdata)
	);

	////////////////////
	// bus arbiter
	////////////////////

	cache_controller cache_controller_i (
		.icache_req_command(icache_req_command),
		.icache_req_addr(icache_req_addr),
		.icache_grant_tag(icache_grant_tag),
		.dcache_req_command(dcache_req_command),
		.dcache_req_addr(dcache_req_addr),
		.dcache_req_wdata(dcache_req_wdata),
		.dcache_grant_tag(dcache_grant_tag),
		.mem_command(mem_command),
		.mem_addr(mem_addr),
		.mem_wdata(mem_wdata),
		.mem_response(mem_response)
	);

endmodule

//--- run.sh
#!/bin/sh
# builds the cache testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
	-f sources.f \
	--top-module mem_subsystem_tb \
	-o mem_subsystem_sim
status=$?
if [ "$status" -ne 0 ]; then
	echo "run.sh: Verilator build failed with status $status"
	exit "$status"
fi

./obj_dir/mem_subsystem_sim
status=$?
if [ "$status" -ne 0 ]; then
	echo "run.sh: simulation ended with status $status"
	exit "$status"
fi

exit 0

//--- sources.f
hdl/mem_bus_pkg.sv
hdl/cache_pkg.sv
hdl/icache.sv
hdl/dcache.sv
hdl/cache_controller.sv
hdl/mem_subsystem.sv
verif/clock_gen.sv
verif/mem_model.sv
verif/mem_subsystem_tb.sv

//--- verif/clock_gen.sv
// testbench clock and power-on reset
`timescale 1ns/1ps

module clock_gen #(
	parameter int HALF_PERIOD = 2,
	parameter int RESET_CYCLES = 3
) (
	output logic clock,
	output logic reset
);

	// 4 ns period
	initial begin
		clock = 1'b0;
		forever #HALF_PERIOD clock = ~clock;
	end

	// reset drops on a falling edge, like every other input
	initial begin
		reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;
	end

endmodule

//--- verif/mem_model.sv
// tagged memory model with random accept stalls and random return latency
`timescale 1ns/1ps

module mem_model
	import mem_bus_pkg::*;
(
	input  logic         clock,
	input  logic         reset,
	input  bus_command_t mem_command,
	input  addr_t        mem_addr,
	input  block_t       mem_wdata,
	output mem_tag_t     mem_response,
	output block_t       mem_rdata,
	output mem_tag_t     mem_tag
);

	localparam block_t FILL_KEY = 64'h9e37_79b9_7f4a_7c15;

	// blocks written by stores, the rest still hold the fill pattern
	block_t written [addr_t];

	// loads on their way back
	mem_tag_t pending_tag [$];
	block_t   pending_data [$];
	int       pending_due [$];

	int       cycle = 0;
	logic     accept_now = 1'b0;
	mem_tag_t next_tag = 4'h1;

	initial begin
		mem_rdata = '0;
		mem_tag = '0;
		void'($urandom(23));
	end

	// reference content of the block holding addr
	function automatic block_t read_block(addr_t addr);
		addr_t base;
		base = {addr[XLEN-1:3], 3'b000};
		if (written.exists(base))
			return written[base];
		return {base, ~base} ^ FILL_KEY;
	endfunction

	////////////////////
	// accept side
	////////////////////

	// refused about one cycle in four
	assign mem_response = (!reset && accept_now && mem_command != BUS_NONE) ? next_tag : '0;

	always @(posedge clock) begin
		cycle++;
		if (mem_response != '0) begin
			if (mem_command == BUS_STORE) begin
				written[{mem_addr[XLEN-1:3], 3'b000}] = mem_wdata;
			end else begin
				pending_tag.push_back(mem_response);
				pending_data.push_back(read_block(mem_addr));
				// back after 1 to 4 cycles
				pending_due.push_back(cycle + int'($urandom_range(3, 0)));
			end
			// zero is never a tag
			next_tag <= (next_tag == 4'hf) ? 4'h1 : next_tag + 4'h1;
		end
	end

	////////////////////
	// return side
	////////////////////

	always @(negedge clock) begin
		int ready;
		ready = -1;
		accept_now <= ($urandom_range(3, 0) != 0);
		// oldest due load goes first, one per cycle
		for (int i = pending_tag.size() - 1; i >= 0; i--)
			if (pending_due[i] <= cycle)
				ready = i;
		if (ready >= 0) begin
			mem_tag <= pending_tag[ready];
			mem_rdata <= pending_data[ready];
			pending_tag.delete(ready);
			pending_data.delete(ready);
			pending_due.delete(ready);
		end else begin
			mem_tag <= '0;
			mem_rdata <= '0;
		end
	end

endmodule

//--- verif/mem_subsystem_tb.sv
// testbench top: directed cache tests, typed compare tasks and run ending
`timescale 1ns/1ps

module mem_subsystem_tb
	import mem_bus_pkg::*;
	import cache_pkg::*;
();

	localparam int WAIT_LIMIT = 64;
	// cache sizes in bytes at the default line counts
	localparam int ICACHE_BYTES = 32 * 8;
	localparam int DCACHE_BYTES = 16 * 8;

	logic         clock;
	logic         reset;
	addr_t        fetch_addr;
	block_t       fetch_data;
	logic         fetch_valid;
	bus_command_t dcache_command;
	addr_t        dcache_addr;
	mem_size_t    dcache_size;
	block_t       dcache_wdata;
	block_t       dcache_rdata;
	logic         dcache_finished;
	bus_command_t mem_command;
	addr_t        mem_addr;
	block_t       mem_wdata;
	mem_tag_t     mem_response;
	block_t       mem_rdata;
	mem_tag_t     mem_tag;

	clock_gen clock_gen_i (
		.clock(clock),
		.reset(reset)
	);

	mem_model model_i (
		.clock(clock),
		.reset(reset),
		.mem_command(mem_command),
		.mem_addr(mem_addr),
		.mem_wdata(mem_wdata),
		.mem_response(mem_response),
		.mem_rdata(mem_rdata),
		.mem_tag(mem_tag)
	);

	mem_subsystem dut_i (
		.clock(clock),
		.reset(reset),
		.fetch_addr(fetch_addr),
		.fetch_data(fetch_data),
		.fetch_valid(fetch_valid),
		.dcache_command(dcache_command),
		.dcache_addr(dcache_addr),
		.dcache_size(dcache_size),
		.dcache_wdata(dcache_wdata),
		.dcache_rdata(dcache_rdata),
		.dcache_finished(dcache_finished),
		.mem_command(mem_command),
		.mem_addr(mem_addr),
		.mem_wdata(mem_wdata),
		.mem_response(mem_response),
		.mem_rdata(mem_rdata),
		.mem_tag(mem_tag)
	);

	////////////////////
	// failure and compares
	////////////////////

	task automatic abort_run();
		$display("SIMULATION FAILED");
		$fatal(1);
	endtask

	task automatic report_timeout(string what);
		$display("Timeout at %0t ns: gave up waiting for %s", $time, what);
		abort_run();
	endtask

	task automatic compare_block(string what, block_t expected, block_t actual);
		if (actual !== expected) begin
			$display("** Error at %0t ns: %s: expected %h, got %h", $time, what, expected, actual);
			abort_run();
		end
	endtask

	task automatic compare_command(string what, bus_command_t expected, bus_command_t actual);
		if (actual !== expected) begin
			$display("** Error at %0t ns: %s: expected %s, got %s", $time, what,
				expected.name(), actual.name());
			abort_run();
		end
	endtask

	task automatic compare_bit(string what, logic expected, logic actual);
		if (actual !== expected) begin
			$display("** Error at %0t ns: %s: expected %b, got %b", $time, what, expected, actual);
			abort_run();
		end
	endtask

	////////////////////
	// expected values
	////////////////////

	// byte by byte, little endian inside the block
	function automatic block_t expected_load(block_t line, addr_t addr, mem_size_t size);
		block_t value;
		int first;
		value = '0;
		first = int'(addr[2:0]);
		for (int b = 0; b < (1 << int'(size)); b++)
			value[8*b +: 8] = line[8*(first + b) +: 8];
		return value;
	endfunction

	function automatic block_t expected_store(block_t line, addr_t addr, mem_size_t size,
			block_t value);
		block_t merged;
		int first;
		merged = line;
		first = int'(addr[2:0]);
		for (int b = 0; b < (1 << int'(size)); b++)
			merged[8*(first + b) +: 8] = value[8*b +: 8];
		return merged;
	endfunction

	////////////////////
	// port drivers
	////////////////////

	task automatic wait_fetch_valid(string what);
		int count;
		count = 0;
		do begin
			@(negedge clock);
			count++;
			if (count > WAIT_LIMIT)
				report_timeout(what);
		end while (!fetch_valid);
	endtask

	// count of falling edges from command to pulse
	task automatic wait_finished(string what, output block_t rdata, output int cycles);
		cycles = 0;
		do begin
			@(negedge clock);
			cycles++;
			if (cycles > WAIT_LIMIT)
				report_timeout(what);
		end while (!dcache_finished);
		rdata = dcache_rdata;
	endtask

	// held command, dropped after the edge that closes the pulse
	task automatic data_access(bus_command_t command, addr_t addr, mem_size_t size,
			block_t wdata, output block_t rdata, output int cycles);
		@(negedge clock);
		dcache_command = command;
		dcache_addr = addr;
		dcache_size = size;
		dcache_wdata = wdata;
		wait_finished("dcache_finished on the data port", rdata, cycles);
		@(negedge clock);
		compare_bit("one finish pulse per command", 1'b0, dcache_finished);
		dcache_command = BUS_NONE;
	endtask

	task automatic load_check(addr_t addr, mem_size_t size);
		block_t rdata;
		int cycles;
		data_access(BUS_LOAD, addr, size, '0, rdata, cycles);
		compare_block("load value", expected_load(model_i.read_block(addr), addr, size), rdata);
	endtask

	task automatic fetch_miss(addr_t addr);
		@(negedge clock);
		fetch_addr = addr;
		#1;
		compare_bit("fetch_valid on a new block", 1'b0, fetch_valid);
		wait_fetch_valid("fetch_valid after a fetch miss");
		compare_block("fetched block", model_i.read_block(addr), fetch_data);
	endtask

	// a hit shows in the same cycle as the address
	task automatic fetch_hit(addr_t addr);
		@(negedge clock);
		fetch_addr = addr;
		#1;
		compare_bit("fetch_valid on a cached block", 1'b1, fetch_valid);
		compare_block("fetched block on a hit", model_i.read_block(addr), fetch_data);
	endtask

	////////////////////
	// tests
	////////////////////

	task automatic test_reset();
		int count;
		// first edge of reset has cleared both caches
		@(negedge clock);
		compare_bit("fetch_valid in reset", 1'b0, fetch_valid);
		compare_bit("dcache_finished in reset", 1'b0, dcache_finished);
		// neither cache asks for the bus while reset is held
		compare_command("bus command in reset", BUS_NONE, mem_command);
		count = 0;
		do begin
			@(posedge clock);
			count++;
			if (count > WAIT_LIMIT)
				report_timeout("reset release");
		end while (reset);
	endtask

	task automatic test_fetch();
		fetch_miss(32'h0000_1000);
		fetch_hit(32'h0000_1004);
	endtask

	task automatic test_sized_loads();
		for (int s = 0; s < 4; s++)
			for (int off = 0; off < 8; off += (1 << s))
				load_check(32'h0000_2040 + addr_t'(off), mem_size_t'(s));
	endtask

	task automatic test_store_then_load();
		addr_t addr;
		block_t value;
		block_t expected;
		block_t rdata;
		int cycles;
		for (int s = 0; s < 4; s++) begin
			// fresh block per size, so every store misses
			addr = 32'h0000_7000 + addr_t'(64 * s + ((s == 3) ? 0 : (1 << s)));
			value = {8{8'(8'hb0 + s)}};
			expected = expected_store(model_i.read_block(addr), addr, mem_size_t'(s), value);
			data_access(BUS_STORE, addr, mem_size_t'(s), value, rdata, cycles);
			compare_block("memory after write-through", expected, model_i.read_block(addr));
			data_access(BUS_LOAD, {addr[31:3], 3'b000}, DOUBLE, '0, rdata, cycles);
			compare_block("double load after store", expected, rdata);
			// line was allocated by the store miss
			compare_bit("load after store miss hits", 1'b1, cycles == 1);
		end
	endtask

	task automatic test_concurrent();
		addr_t fetch_target;
		addr_t data_target;
		logic data_done;
		logic fetch_done;
		int count;
		fetch_target = 32'h0000_3100;
		data_target = 32'h0000_4208;
		@(negedge clock);
		dcache_command = BUS_LOAD;
		dcache_addr = data_target;
		dcache_size = DOUBLE;
		// data miss is on the bus two edges later
		@(negedge clock);
		@(negedge clock);
		fetch_addr = fetch_target;
		#1;
		compare_command("bus command with both misses", BUS_LOAD, mem_command);
		compare_block("data address wins the bus", block_t'(data_target), block_t'(mem_addr));
		data_done = 1'b0;
		fetch_done = 1'b0;
		count = 0;
		while (!(data_done && fetch_done)) begin
			@(negedge clock);
			count++;
			if (count > WAIT_LIMIT)
				report_timeout("concurrent fetch and data misses");
			if (dut_i.icache_req_command != BUS_NONE && dut_i.dcache_req_command != BUS_NONE)
				compare_block("data address first on the bus", block_t'(data_target),
					block_t'(mem_addr));
			if (dcache_finished) begin
				compare_bit("one finish pulse per command", 1'b0, data_done);
				compare_block("concurrent load", model_i.read_block(data_target), dcache_rdata);
				data_done = 1'b1;
			end else if (data_done) begin
				dcache_command = BUS_NONE;
			end
			if (fetch_valid && !fetch_done) begin
				compare_block("concurrent fetch", model_i.read_block(fetch_target), fetch_data);
				fetch_done = 1'b1;
			end
		end
		@(negedge clock);
		dcache_command = BUS_NONE;
	endtask

	// same index on each cache, so every access evicts the other
	task automatic test_eviction();
		addr_t fetch_a;
		addr_t data_a;
		fetch_a = 32'h0000_5010;
		data_a = 32'h0000_6020;
		for (int round = 0; round < 3; round++) begin
			fetch_miss(fetch_a);
			fetch_miss(fetch_a + ICACHE_BYTES);
			load_check(data_a, DOUBLE);
			load_check(data_a + DCACHE_BYTES, WORD);
		end
	endtask

	initial begin
		fetch_addr = '0;
		dcache_command = BUS_NONE;
		dcache_addr = '0;
		dcache_size = BYTE;
		dcache_wdata = '0;
		test_reset();
		test_fetch();
		test_sized_loads();
		test_store_then_load();
		test_concurrent();
		test_eviction();
		$display("SIMULATION PASSED");
		$finish;
	end

endmodule
